// ==== include/simplez_cfg.svh ====
// Build-time sizes: TXQ depth must be a power of two, AW must stay 9 to match the 12-bit format
`ifndef SIMPLEZ_CFG_SVH
`define SIMPLEZ_CFG_SVH

// --------------------------------------------------
// Memory
// --------------------------------------------------

// RAM address width, also the address field of an instruction
`define SIMPLEZ_AW 9

// --------------------------------------------------
// Screen path
// --------------------------------------------------

// Entries in the screen transmit queue (power of two)
`define SIMPLEZ_TXQ_DEPTH 4

// Clock cycles per serial bit
`define SIMPLEZ_BAUD_DIV 8

// --------------------------------------------------
// Core
// --------------------------------------------------

`define SIMPLEZ_WAIT_CYCLES 20  // Cycles spent in EXEC2 by WAIT

`endif

// ==== design/simplez_isa_pkg.sv ====
// Instruction-set types; word is fixed at 12 bits and the address field follows SIMPLEZ_AW
`include "simplez_cfg.svh"

package simplez_isa_pkg;

  // --------------------------------------------------
  // Basic machine types
  // --------------------------------------------------
  typedef logic [11:0]            word_t;  // Data and instruction word
  typedef logic [`SIMPLEZ_AW-1:0] addr_t;  // Word address

  // Base opcodes, top three bits of the word
  typedef enum logic [2:0] {
    ST  = 3'd0,  // Store accumulator
    LD  = 3'd1,  // Load accumulator
    ADD = 3'd2,  // Add memory to accumulator
    BR  = 3'd3,  // Unconditional branch
    BZ  = 3'd4,  // Branch if Z set
    CLR = 3'd5,  // Clear accumulator
    DEC = 3'd6,  // Decrement accumulator
    EXT = 3'd7   // Extended group, see ext_op_e
  } opcode_e;

  // Extended opcodes, top four bits when the base opcode is EXT
  typedef enum logic [3:0] {
    HALTE = 4'hE,  // Stop forever
    WAIT  = 4'hF   // Fixed delay
  } ext_op_e;

  // --------------------------------------------------
  // Instruction word, two decodings of the same 12 bits
  // --------------------------------------------------
  typedef struct packed {
    opcode_e op;
    addr_t   addr;  // Operand or branch target
  } base_fmt_t;

  typedef struct packed {
    ext_op_e    op;
    logic [7:0] unused;  // Don't care for HALTE and WAIT
  } ext_fmt_t;

  typedef union packed {
    base_fmt_t base;
    ext_fmt_t  ext;
  } instr_u;

  // Core to RAM request, sampled on the rising edge
  typedef struct packed {
    logic  cs;     // Chip select
    logic  we;     // Write when set, read otherwise
    addr_t addr;
    word_t wdata;
  } mem_req_t;

endpackage

// ==== design/simplez_io_pkg.sv ====
// Peripheral map and I/O bundles; everything at IO_BASE and above is kept out of RAM

package simplez_io_pkg;

  // --------------------------------------------------
  // Memory-mapped peripherals
  // --------------------------------------------------
  localparam simplez_isa_pkg::addr_t IO_BASE         = 9'h1F8;  // First non-RAM address
  localparam simplez_isa_pkg::addr_t LEDS_ADDR       = 9'h1FB;  // Write only
  localparam simplez_isa_pkg::addr_t SCR_STATUS_ADDR = 9'h1FC;  // Bit 0 is queue not full
  localparam simplez_isa_pkg::addr_t SCR_DATA_ADDR   = 9'h1FD;  // Write only
  localparam simplez_isa_pkg::addr_t KBD_DATA_ADDR   = 9'h1FE;  // No keyboard, reads 0
  localparam simplez_isa_pkg::addr_t KBD_STATUS_ADDR = 9'h1FF;  // Reads 0

  // Program load port, used while the core is in reset
  typedef struct packed {
    logic                   en;
    simplez_isa_pkg::addr_t addr;
    simplez_isa_pkg::word_t data;
  } ram_load_t;

  // Core to queue, single-cycle strobe
  typedef struct packed {
    logic       push;
    logic [7:0] data;
  } tx_push_t;

  // Queue head as seen by the transmitter
  typedef struct packed {
    logic       valid;  // Level, high while not empty
    logic [7:0] data;
  } tx_head_t;

endpackage

// ==== design/simplez_ram.sv ====
// Single clock RAM with no reset; the load port wins over a core write to any address
`timescale 1ns/100ps
`include "simplez_cfg.svh"

module simplez_ram (
  input  logic                      clk,
  input  simplez_isa_pkg::mem_req_t core_req,  // Core access
  input  simplez_io_pkg::ram_load_t load,      // Program loader
  output simplez_isa_pkg::word_t    rdata      // Valid one cycle after cs
);
  import simplez_isa_pkg::*;

  word_t mem [2**`SIMPLEZ_AW];

  // Write port, loader first
  always_ff @(posedge clk) begin
    if (load.en)
      mem[load.addr] <= load.data;
    else if (core_req.cs && core_req.we)
      mem[core_req.addr] <= core_req.wdata;
  end

  // Synchronous read, old data on a same-address write
  always_ff @(posedge clk) begin
    if (core_req.cs)
      rdata <= mem[core_req.addr];
  end

endmodule

// ==== design/simplez_core.sv ====
// Simplez control unit and datapath; a screen store stalls in EXEC1 while the queue is full
`timescale 1ns/100ps
`include "simplez_cfg.svh"

module simplez_core (
  input  logic                      clk,
  input  logic                      rstn,
  output simplez_isa_pkg::mem_req_t mem_req,    // To RAM, combinational
  input  simplez_isa_pkg::word_t    mem_rdata,  // Read data, one cycle latency
  input  logic                      txq_full,   // Screen queue level
  output simplez_io_pkg::tx_push_t  tx_push,    // Screen byte strobe
  output logic [7:0]                leds,
  output logic                      stop        // Sticky after HALTE
);
  import simplez_isa_pkg::*;
  import simplez_io_pkg::*;

  localparam int WAIT_W = $clog2(`SIMPLEZ_WAIT_CYCLES + 1);

  typedef enum logic [2:0] {INIT, FETCH, EXEC1, EXEC2, END} state_e;

  state_e            state;
  state_e            next_state;
  addr_t             pc;        // Program counter
  instr_u            ir;        // Instruction register
  word_t             acc;       // Accumulator
  logic              z;         // Set when acc was loaded with zero
  logic [WAIT_W-1:0] wait_cnt;

  // Microorders
  logic  pc_inc;
  logic  pc_load;
  logic  a_load;
  logic  halt;
  logic  wait_load;
  logic  led_we;
  logic  push_now;
  word_t alu_res;   // Value written to acc on a_load

  logic  is_io;     // Operand address is a peripheral
  word_t io_rdata;
  word_t operand;   // Second ALU input

  // --------------------------------------------------
  // Peripheral decode
  // --------------------------------------------------
  assign is_io = (ir.base.addr >= IO_BASE);

  always_comb begin
    case (ir.base.addr)
      SCR_STATUS_ADDR: io_rdata = {11'b0, ~txq_full};  // Room in the queue
      KBD_DATA_ADDR,
      KBD_STATUS_ADDR: io_rdata = '0;                  // No keyboard fitted
      default:         io_rdata = '0;
    endcase
  end

  // RAM data arrives in EXEC2 for the EXEC1 read
  assign operand = is_io ? io_rdata : mem_rdata;

  // --------------------------------------------------
  // Control unit
  // --------------------------------------------------
  always_comb begin
    next_state    = state;
    pc_inc        = 1'b0;
    pc_load       = 1'b0;
    a_load        = 1'b0;
    alu_res       = acc;
    halt          = 1'b0;
    wait_load     = 1'b0;
    led_we        = 1'b0;
    push_now      = 1'b0;
    mem_req.cs    = 1'b0;
    mem_req.we    = 1'b0;
    mem_req.addr  = (state == INIT) ? pc : ir.base.addr;  // Fetch from pc, else operand
    mem_req.wdata = acc;

    case (state)
      INIT: begin
        mem_req.cs = 1'b1;  // Instruction read
        next_state = FETCH;
      end

      FETCH: next_state = EXEC1;  // ir loads here

      EXEC1: begin
        case (ir.base.op)
          ST: begin
            next_state = END;
            if (!is_io) begin
              mem_req.cs = 1'b1;
              mem_req.we = 1'b1;
            end else if (ir.base.addr == LEDS_ADDR) begin
              led_we = 1'b1;
            end else if (ir.base.addr == SCR_DATA_ADDR) begin
              if (txq_full)
                next_state = EXEC1;  // Back-pressure, hold until room
              else
                push_now = 1'b1;
            end
          end
          LD, ADD: begin
            mem_req.cs = !is_io;  // Peripherals answer combinationally
            next_state = EXEC2;
          end
          BR: begin
            pc_load    = 1'b1;
            next_state = INIT;
          end
          BZ: begin
            if (z) begin
              pc_load    = 1'b1;
              next_state = INIT;
            end else begin
              next_state = END;
            end
          end
          CLR: begin
            a_load     = 1'b1;
            alu_res    = '0;
            next_state = END;
          end
          DEC: begin
            a_load     = 1'b1;
            alu_res    = acc - 1'b1;  // Wraps 0 to FFF
            next_state = END;
          end
          EXT: begin
            case (ir.ext.op)
              HALTE: halt = 1'b1;  // Stay here for good
              WAIT: begin
                wait_load  = 1'b1;
                next_state = EXEC2;
              end
              default: next_state = END;  // Unknown extension is a nop
            endcase
          end
        endcase
      end

      EXEC2: begin
        next_state = END;
        case (ir.base.op)
          LD: begin
            a_load  = 1'b1;
            alu_res = operand;
          end
          ADD: begin
            a_load  = 1'b1;
            alu_res = acc + operand;  // 12-bit wrap
          end
          EXT:     if (wait_cnt != '0) next_state = EXEC2;  // WAIT delay
          default: next_state = END;
        endcase
      end

      END: begin
        pc_inc     = 1'b1;
        next_state = INIT;
      end

      default: next_state = INIT;
    endcase
  end

  assign tx_push = '{push: push_now, data: acc[7:0]};

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= INIT;
      pc    <= '0;
      acc   <= '0;
      z     <= 1'b0;
    end else begin
      state <= next_state;
      if (pc_load)
        pc <= ir.base.addr;
      else if (pc_inc)
        pc <= pc + 1'b1;
      if (a_load) begin
        acc <= alu_res;
        z   <= (alu_res == '0);  // Z tracks every acc load
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH)
      ir <= mem_rdata;
  end

  // WAIT timer, loaded in EXEC1 and counted down in EXEC2
  always_ff @(posedge clk) begin
    if (!rstn)
      wait_cnt <= '0;
    else if (wait_load)
      wait_cnt <= WAIT_W'(`SIMPLEZ_WAIT_CYCLES - 1);
    else if (state == EXEC2 && wait_cnt != '0)
      wait_cnt <= wait_cnt - 1'b1;
  end

  // LED port and stop flag
  always_ff @(posedge clk) begin
    if (!rstn) begin
      leds <= '0;
      stop <= 1'b0;
    end else begin
      if (led_we)
        leds <= acc[7:0];
      if (halt)
        stop <= 1'b1;
    end
  end

endmodule

// ==== design/tx_queue.sv ====
// Screen byte FIFO; depth must be a power of two and a push while full is not blocked here
`timescale 1ns/100ps
`include "simplez_cfg.svh"

module tx_queue (
  input  logic                     clk,
  input  logic                     rstn,
  input  simplez_io_pkg::tx_push_t push,  // From core
  input  logic                     pop,   // From transmitter
  output simplez_io_pkg::tx_head_t head,  // Oldest byte
  output logic                     full
);
  localparam int DEPTH = `SIMPLEZ_TXQ_DEPTH;
  localparam int PW    = $clog2(DEPTH);

  logic [7:0]    buf_mem [DEPTH];  // Payload, no reset
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;            // Occupancy, 0 to DEPTH

  // Storage
  always_ff @(posedge clk) begin
    if (push.push)
      buf_mem[wr_ptr] <= push.data;
  end

  // --------------------------------------------------
  // Pointers and count
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push.push)
        wr_ptr <= wr_ptr + 1'b1;  // Natural wrap
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push.push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or none
      endcase
    end
  end

  assign full = (count == (PW + 1)'(DEPTH));
  assign head = '{valid: (count != '0), data: buf_mem[rd_ptr]};

endmodule

// ==== design/uart_tx.sv ====
// 8N1 transmitter; takes a byte straight off the queue head, frames run back to back
`timescale 1ns/100ps
`include "simplez_cfg.svh"

module uart_tx (
  input  logic                     clk,
  input  logic                     rstn,
  input  simplez_io_pkg::tx_head_t head,  // Queue head
  output logic                     pop,   // Byte taken this cycle
  output logic                     tx     // Serial line, idles high
);
  localparam int DIV = `SIMPLEZ_BAUD_DIV;
  localparam int BW  = $clog2(DIV + 1);

  logic          busy;       // Frame in progress
  logic [BW-1:0] baud_cnt;   // Cycle within the bit
  logic [3:0]    bit_idx;    // 0 start, 1 to 8 data, 9 stop
  logic [8:0]    shreg;      // Data bits with the stop bit above
  logic          bit_end;
  logic          frame_end;

  assign bit_end   = busy && (baud_cnt == BW'(DIV - 1));
  assign frame_end = bit_end && (bit_idx == 4'd9);

  // Pull a byte when idle or as the stop bit finishes
  assign pop = head.valid && (!busy || frame_end);

  // --------------------------------------------------
  // Bit timing and line driver
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end else if (pop) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b0;  // Start bit
    end else if (frame_end) begin
      busy <= 1'b0;      // Line already high from the stop bit
    end else if (bit_end) begin
      baud_cnt <= '0;
      bit_idx  <= bit_idx + 1'b1;
      tx       <= shreg[0];  // LSB first, then the stop 1
    end else if (busy) begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Shift register, refilled with ones from the top
  always_ff @(posedge clk) begin
    if (pop)
      shreg <= {1'b1, head.data};
    else if (bit_end)
      shreg <= {1'b1, shreg[8:1]};
  end

endmodule

// ==== design/simplez_top.sv ====
// Simplez system; load port is meant for use only while rstn is low, no keyboard input
`timescale 1ns/100ps

module simplez_top (
  input  logic                      clk,
  input  logic                      rstn,
  input  simplez_io_pkg::ram_load_t load,  // Program loader
  output logic [7:0]                leds,
  output logic                      stop,
  output logic                      tx     // Screen serial line
);
  import simplez_isa_pkg::*;
  import simplez_io_pkg::*;

  // --------------------------------------------------
  // Interconnect
  // --------------------------------------------------
  mem_req_t core_req;
  word_t    ram_rdata;
  tx_push_t txq_push;  // Producer side
  tx_head_t txq_head;  // Consumer side
  logic     txq_full;
  logic     tx_pop;

  simplez_core CORE (
    .clk       (clk),
    .rstn      (rstn),
    .mem_req   (core_req),
    .mem_rdata (ram_rdata),
    .txq_full  (txq_full),
    .tx_push   (txq_push),
    .leds      (leds),
    .stop      (stop)
  );

  simplez_ram RAM (
    .clk      (clk),
    .core_req (core_req),
    .load     (load),
    .rdata    (ram_rdata)
  );

  tx_queue TXQ (
    .clk  (clk),
    .rstn (rstn),
    .push (txq_push),
    .pop  (tx_pop),
    .head (txq_head),
    .full (txq_full)
  );

  uart_tx TX (
    .clk  (clk),
    .rstn (rstn),
    .head (txq_head),
    .pop  (tx_pop),
    .tx   (tx)
  );

endmodule

// ==== tests/simplez_properties.sv ====
// Bound into tx_queue and simplez_core; unused inputs of each binding are tied off to constants
`timescale 1ns/100ps

module simplez_properties (
  input logic clk,
  input logic rstn,
  input logic push,   // Queue push strobe
  input logic pop,    // Queue pop strobe
  input logic full,
  input logic empty,
  input logic stop    // Core halt flag
);

  // --------------------------------------------------
  // Queue handshake
  // --------------------------------------------------
  no_push_full: assert property (@(posedge clk) disable iff (!rstn) push |-> !full)
    else $error("Push while the screen queue is full");

  no_pop_empty: assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty)
    else $error("Pop while the screen queue is empty");

  push_pulse: assert property (@(posedge clk) disable iff (!rstn) push |=> !push)
    else $error("Push strobe held for more than one cycle");

  // Once halted the core stays halted until reset
  stop_sticky: assert property (@(posedge clk) disable iff (!rstn) stop |=> stop)
    else $error("stop fell without reset");

endmodule

bind tx_queue simplez_properties PROPS_TXQ (
  .clk(clk), .rstn(rstn), .push(push.push), .pop(pop),
  .full(full), .empty(!head.valid), .stop(1'b0)
);

bind simplez_core simplez_properties PROPS_CORE (
  .clk(clk), .rstn(rstn), .push(tx_push.push), .pop(1'b0),
  .full(txq_full), .empty(1'b0), .stop(stop)
);

// ==== tests/simplez_tb.sv ====
// Random programs from LCG seed 66, loaded while reset is held; assumes 8N1 output and 4 ns clock
`timescale 1ns/100ps
`include "simplez_cfg.svh"

module simplez_tb;
  import simplez_isa_pkg::*;
  import simplez_io_pkg::*;

  localparam int NUM_PROGS = 6;
  localparam int PROG_LEN  = 48;                  // HALTE sits at this address
  localparam int DIV       = `SIMPLEZ_BAUD_DIV;
  localparam int BURST     = 2 * (`SIMPLEZ_TXQ_DEPTH + 3);  // Words in a screen burst
  localparam int TIMEOUT   = 40000;               // Cycles allowed per wait loop

  logic        clk = 1'b0;
  logic        rstn;
  ram_load_t   load;
  logic [7:0]  leds;
  logic        stop;
  logic        tx;

  word_t       image [2**`SIMPLEZ_AW];  // Program plus data as loaded
  logic [7:0]  exp_bytes[$];            // Model screen output
  logic [7:0]  exp_leds[$];             // Model LED changes in order
  logic [7:0]  exp_final_leds;
  logic [7:0]  rx_bytes[$];             // Decoded from the tx line
  logic [7:0]  seen_leds[$];
  logic [7:0]  last_leds;
  int unsigned lcg_state;

  simplez_top UUT (.clk(clk), .rstn(rstn), .load(load), .leds(leds), .stop(stop), .tx(tx));

  always #2 clk = ~clk;  // 4 ns period

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7FFF;  // Upper bits are the better ones
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() % n);
  endfunction

  function automatic addr_t rand_data_addr();
    return addr_t'(9'h100 + rand_below(248));  // 0x100 to 0x1F7
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("No progress after %0d cycles while waiting for %s", TIMEOUT, what);
    $display("Some tests failed");
    $fatal(1, "Timeout");
  endtask

  // --------------------------------------------------
  // Program generator with forward branches only
  // --------------------------------------------------
  task automatic build_program();
    int wait_at;
    int pc;
    int kind;
    int tgt;
    int burst_left;
    wait_at    = 1 + rand_below(PROG_LEN - 2);
    pc         = 0;
    burst_left = 0;
    for (int a = 0; a < 2**`SIMPLEZ_AW; a++)
      image[a] = word_t'(next_rand()) ^ word_t'(a);  // Random data with the address mixed in
    while (pc < PROG_LEN) begin
      tgt = pc + 1 + rand_below(4);
      if (pc < wait_at && tgt > wait_at)
        tgt = wait_at;  // Never jump over the WAIT
      if (tgt > PROG_LEN)
        tgt = PROG_LEN;
      if (pc == wait_at) begin
        image[pc] = {WAIT, 8'h00};
        pc++;
      end else if (burst_left > 0) begin
        image[pc] = (burst_left % 2 == 0) ? {ST, SCR_DATA_ADDR} : {DEC, 9'h000};
        burst_left--;
        pc++;
      end else begin
        kind = rand_below(16);
        case (kind)
          0, 1, 2: image[pc] = {LD, rand_data_addr()};
          3, 4, 5: image[pc] = {ADD, rand_data_addr()};
          6, 7:    image[pc] = {ST, rand_data_addr()};
          8:       image[pc] = {ST, LEDS_ADDR};
          9, 10:   image[pc] = {ST, SCR_DATA_ADDR};
          11:      image[pc] = {CLR, 9'h000};
          12:      image[pc] = {DEC, 9'h000};
          13:      image[pc] = {BZ, addr_t'(tgt)};
          14:      image[pc] = {BR, addr_t'(tgt)};
          default: burst_left = BURST;  // Store run longer than the queue
        endcase
        if (kind != 15)
          pc++;
      end
    end
    image[PROG_LEN] = {HALTE, 8'h00};
  endtask

  // --------------------------------------------------
  // Instruction-set model
  // --------------------------------------------------
  task automatic run_model();
    word_t      mem [2**`SIMPLEZ_AW];
    word_t      w;
    word_t      acc;
    logic       z;
    logic [8:0] a;
    int         pc;
    int         steps;
    logic       halted;
    logic [7:0] led_val;
    mem     = image;
    acc     = '0;
    z       = 1'b0;
    pc      = 0;
    steps   = 0;
    halted  = 1'b0;
    led_val = 8'h00;
    exp_bytes.delete();
    exp_leds.delete();
    while (!halted && steps < 10000) begin
      w = mem[pc];
      a = w[8:0];
      steps++;
      case (w[11:9])
        3'd0: begin  // ST
          if (a == SCR_DATA_ADDR)
            exp_bytes.push_back(acc[7:0]);
          else if (a == LEDS_ADDR) begin
            if (acc[7:0] != led_val)
              exp_leds.push_back(acc[7:0]);
            led_val = acc[7:0];
          end else if (a < IO_BASE)
            mem[a] = acc;
          pc++;
        end
        3'd1: begin  // LD
          acc = mem[a];
          z   = (acc == 12'h000);
          pc++;
        end
        3'd2: begin  // ADD
          acc = acc + mem[a];
          z   = (acc == 12'h000);
          pc++;
        end
        3'd3: pc = a;                     // BR
        3'd4: pc = z ? int'(a) : pc + 1;  // BZ
        3'd5: begin  // CLR
          acc = '0;
          z   = 1'b1;
          pc++;
        end
        3'd6: begin  // DEC
          acc = acc - 12'd1;
          z   = (acc == 12'h000);
          pc++;
        end
        default: begin
          if (w[11:8] == 4'hE)
            halted = 1'b1;
          else
            pc++;  // WAIT only delays
        end
      endcase
    end
    exp_final_leds = led_val;
  endtask

  // Reset for two cycles and then fill RAM through the load port with reset still low
  task automatic load_program();
    @(posedge clk);
    #1;
    rstn = 1'b0;
    load = '0;
    repeat (2) begin
      @(posedge clk);
      #1;
    end
    for (int a = 0; a < int'(IO_BASE); a++) begin
      load = '{en: 1'b1, addr: addr_t'(a), data: image[a]};
      @(posedge clk);
      #1;
    end
    load = '0;
    rx_bytes.delete();
    seen_leds.delete();
    rstn = 1'b1;
  endtask

  // --------------------------------------------------
  // Output monitors sampling on the falling edge
  // --------------------------------------------------
  always @(negedge clk) begin : led_monitor
    if (rstn !== 1'b1)
      last_leds = 8'h00;
    else if (leds !== last_leds) begin
      seen_leds.push_back(leds);
      last_leds = leds;
    end
  end

  always begin : serial_decoder
    logic [7:0] rx;
    @(negedge clk);
    if (rstn === 1'b1 && tx === 1'b0) begin
      repeat (DIV / 2) @(negedge clk);  // Centre of the start bit
      check_value(tx, 1'b0, "start bit");
      for (int i = 0; i < 8; i++) begin
        repeat (DIV) @(negedge clk);
        rx[i] = tx;  // LSB first
      end
      repeat (DIV) @(negedge clk);
      check_value(tx, 1'b1, "stop bit");
      rx_bytes.push_back(rx);
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int cycles;
    lcg_state = 66;
    rstn      = 1'b0;
    load      = '0;
    last_leds = 8'h00;
    for (int p = 0; p < NUM_PROGS; p++) begin
      build_program();
      run_model();
      load_program();
      @(negedge clk);
      check_value(stop, 1'b0, "stop after reset");
      check_value(tx, 1'b1, "tx after reset");
      check_value(leds, 8'h00, "leds after reset");
      cycles = 0;
      while (stop !== 1'b1) begin  // Run to HALTE
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT)
          fail_timeout("stop");
      end
      cycles = 0;
      while (rx_bytes.size() < exp_bytes.size()) begin  // Drain the queue
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT)
          fail_timeout("screen frames");
        check_value(stop, 1'b1, "stop held while draining");
      end
      cycles = 0;
      while (cycles < 3 * 10 * DIV) begin  // Room for any stray frame
        @(negedge clk);
        cycles++;
        check_value(stop, 1'b1, "stop held after halt");
      end
      check_value(rx_bytes.size(), exp_bytes.size(), "screen byte count");
      foreach (exp_bytes[i])
        check_value(rx_bytes[i], exp_bytes[i], $sformatf("prog %0d byte %0d", p, i));
      check_value(seen_leds.size(), exp_leds.size(), "LED change count");
      foreach (exp_leds[i])
        check_value(seen_leds[i], exp_leds[i], $sformatf("prog %0d LED change %0d", p, i));
      check_value(leds, exp_final_leds, "final leds");
    end
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== simplez.f ====
+incdir+include
design/simplez_isa_pkg.sv
design/simplez_io_pkg.sv
design/simplez_ram.sv
design/simplez_core.sv
design/tx_queue.sv
design/uart_tx.sv
design/simplez_top.sv
tests/simplez_properties.sv
tests/simplez_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = simplez_tb
FILELIST  = simplez.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
